/* logic/cache_pkg.sv */
// L1 data cache package with address field widths, word and block types, miss FSM states
`default_nettype none

package cache_pkg;

    // ------------------------------------------------------------
    // Address split | tag (26) | set (2) | word offset (2) |
    // ------------------------------------------------------------
    localparam int WORD_W     = 32;                         // Processor data word
    localparam int ADDR_W     = 30;                         // Word address
    localparam int OFFSET_W   = 2;                          // Word select inside a block
    localparam int SET_W      = 2;
    localparam int NUM_SETS   = 1 << SET_W;
    localparam int TAG_W      = ADDR_W - SET_W - OFFSET_W;
    localparam int BLOCK_W    = WORD_W << OFFSET_W;         // Four words per block
    localparam int MEM_ADDR_W = TAG_W + SET_W;              // Block address with tag then set

    // ------------------------------------------------------------
    // Data types
    // ------------------------------------------------------------
    typedef logic [WORD_W-1:0]     word_t;
    typedef logic [BLOCK_W-1:0]    block_t;      // Word 0 sits in the low bits
    typedef logic [ADDR_W-1:0]     word_addr_t;
    typedef logic [MEM_ADDR_W-1:0] block_addr_t;
    typedef logic [TAG_W-1:0]      tag_t;
    typedef logic [SET_W-1:0]      set_idx_t;

    // Miss handling FSM
    typedef enum logic [1:0] {
        MISS_IDLE       = 2'd0,  // Hits served while waiting for a miss
        MISS_WRITE_BACK = 2'd1,  // Dirty victim going out to memory
        MISS_ALLOCATE   = 2'd2   // Requested block coming in
    } miss_state_e;

endpackage

`default_nettype wire

/* logic/way_access_if.sv */
// Way access interface between the miss controller and the cache way storage
`default_nettype none

interface way_access_if
    import cache_pkg::*;
();

    // Lookup results driven by the storage
    logic   hit;           // Request matches a valid way of its set
    logic   victim_dirty;  // LRU way of the set is valid and dirty
    tag_t   victim_tag;
    block_t victim_block;

    // Fill path driven by the controller
    logic   fill_en;       // One-cycle strobe that writes the LRU way
    block_t fill_block;

    modport storage (
        output hit,
        output victim_dirty,
        output victim_tag,
        output victim_block,
        input  fill_en,
        input  fill_block
    );

    modport controller (
        input  hit,
        input  victim_dirty,
        input  victim_tag,
        input  victim_block,
        output fill_en,
        output fill_block
    );

endinterface

`default_nettype wire

/* logic/cache_ways.sv */
// Two-way cache storage with tag compare, word read and write hits, LRU and block fills
`default_nettype none

module cache_ways
    import cache_pkg::*;
(
    input  wire                    clk,
    input  wire                    rst_n,

    // Processor request
    input  wire                    i_read,
    input  wire                    i_write,
    input  wire word_addr_t        i_addr,
    input  wire word_t             i_wdata,
    output word_t                  o_rdata,
    output logic                   o_stall,

    // Lookup results and fill path
    way_access_if.storage          ways
);

    // ------------------------------------------------------------
    // Request fields
    // ------------------------------------------------------------
    tag_t                req_tag;
    set_idx_t            req_set;
    logic [OFFSET_W-1:0] req_off;
    logic                req_valid;

    assign req_tag   = i_addr[ADDR_W-1 -: TAG_W];
    assign req_set   = i_addr[OFFSET_W +: SET_W];
    assign req_off   = i_addr[OFFSET_W-1:0];
    assign req_valid = i_read | i_write;

    // ------------------------------------------------------------
    // Storage arrays indexed by way first
    // ------------------------------------------------------------
    logic [1:0][NUM_SETS-1:0] valid_q;
    logic [1:0][NUM_SETS-1:0] dirty_q;
    logic [NUM_SETS-1:0]      lru_q;     // Victim way per set

    tag_t   tag_q  [2][NUM_SETS];
    block_t data_q [2][NUM_SETS];

    // ------------------------------------------------------------
    // Lookup
    // ------------------------------------------------------------
    logic [1:0] way_hit;
    logic       hit_way;
    logic       victim_way;

    always_comb begin
        for (int w = 0; w < 2; w++) begin
            way_hit[w] = valid_q[w][req_set] && (tag_q[w][req_set] == req_tag);
        end
    end

    assign hit_way    = way_hit[1];       // Way 0 unless way 1 matches
    assign victim_way = lru_q[req_set];

    assign ways.hit     = |way_hit;
    assign o_stall      = req_valid & ~ways.hit;
    assign o_rdata      = data_q[hit_way][req_set][req_off*WORD_W +: WORD_W];

    // Victim seen by the controller
    assign ways.victim_dirty = valid_q[victim_way][req_set] & dirty_q[victim_way][req_set];
    assign ways.victim_tag   = tag_q[victim_way][req_set];
    assign ways.victim_block = data_q[victim_way][req_set];

    // ------------------------------------------------------------
    // State bits
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= '0;
            dirty_q <= '0;
            lru_q   <= '0;                            // Way 0 is the first victim
        end else if (ways.fill_en) begin
            valid_q[victim_way][req_set] <= 1'b1;
            dirty_q[victim_way][req_set] <= 1'b0;     // Every fill arrives clean
        end else if (req_valid && ways.hit) begin
            lru_q[req_set] <= ~hit_way;               // Other way becomes the victim
            if (i_write) begin
                dirty_q[hit_way][req_set] <= 1'b1;
            end
        end
    end

    // Tags and data
    always_ff @(posedge clk) begin
        if (ways.fill_en) begin
            tag_q[victim_way][req_set]  <= req_tag;
            data_q[victim_way][req_set] <= ways.fill_block;
        end else if (i_write && ways.hit) begin
            data_q[hit_way][req_set][req_off*WORD_W +: WORD_W] <= i_wdata;
        end
    end

    // A block is only ever filled into a set that missed on it
    a_single_way_hit : assert property (
        @(posedge clk) disable iff (!rst_n)
        !(way_hit[0] && way_hit[1])
    );

endmodule

`default_nettype wire

/* logic/miss_controller.sv */
// Miss controller FSM that writes back dirty victims and allocates blocks from memory
`default_nettype none

module miss_controller
    import cache_pkg::*;
(
    input  wire                    clk,
    input  wire                    rst_n,

    // Processor request
    input  wire                    i_read,
    input  wire                    i_write,
    input  wire word_addr_t        i_addr,

    // Block memory port
    input  wire block_t            i_mem_rdata,
    input  wire                    i_mem_ready,
    output logic                   o_mem_read,
    output logic                   o_mem_write,
    output block_addr_t            o_mem_addr,
    output block_t                 o_mem_wdata,

    // Lookup results and fill path
    way_access_if.controller       ctrl
);

    // ------------------------------------------------------------
    // Request decode
    // ------------------------------------------------------------
    set_idx_t    req_set;
    block_addr_t req_block_addr;
    logic        req_miss;

    assign req_set        = i_addr[OFFSET_W +: SET_W];
    assign req_block_addr = i_addr[ADDR_W-1:OFFSET_W];
    assign req_miss       = (i_read | i_write) & ~ctrl.hit;

    // ------------------------------------------------------------
    // Next state
    // ------------------------------------------------------------
    miss_state_e state_q;
    miss_state_e state_d;

    always_comb begin
        state_d = state_q;
        case (state_q)
            MISS_IDLE: begin
                if (req_miss) begin
                    state_d = ctrl.victim_dirty ? MISS_WRITE_BACK : MISS_ALLOCATE;
                end
            end
            MISS_WRITE_BACK: begin
                if (i_mem_ready) begin
                    state_d = MISS_ALLOCATE;
                end
            end
            MISS_ALLOCATE: begin
                if (i_mem_ready) begin
                    state_d = MISS_IDLE;              // Hit follows on the next cycle
                end
            end
            default: begin
                state_d = MISS_IDLE;
            end
        endcase
    end

    // State and request levels that follow the next state
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q     <= MISS_IDLE;
            o_mem_read  <= 1'b0;
            o_mem_write <= 1'b0;
        end else begin
            state_q     <= state_d;
            o_mem_write <= (state_d == MISS_WRITE_BACK);
            o_mem_read  <= (state_d == MISS_ALLOCATE);
        end
    end

    // Address and write data load only when a new request starts
    always_ff @(posedge clk) begin
        if (state_q == MISS_IDLE && state_d == MISS_WRITE_BACK) begin
            o_mem_addr  <= {ctrl.victim_tag, req_set};   // Victim block address
            o_mem_wdata <= ctrl.victim_block;
        end else if (state_q != MISS_ALLOCATE && state_d == MISS_ALLOCATE) begin
            o_mem_addr  <= req_block_addr;
        end
    end

    // ------------------------------------------------------------
    // Fill strobe in the same cycle as the read ready
    // ------------------------------------------------------------
    assign ctrl.fill_en    = (state_q == MISS_ALLOCATE) && i_mem_ready;
    assign ctrl.fill_block = i_mem_rdata;

    a_mem_one_request : assert property (
        @(posedge clk) disable iff (!rst_n)
        !(o_mem_read && o_mem_write)
    );

    // Request stays put until memory answers
    a_mem_req_stable : assert property (
        @(posedge clk) disable iff (!rst_n)
        (o_mem_read || o_mem_write) && !i_mem_ready
            |=> $stable(o_mem_addr) && $stable({o_mem_read, o_mem_write})
    );

endmodule

`default_nettype wire

/* logic/l1_dcache.sv */
// Top level of the 2-way write-back L1 data cache joining the way storage and miss controller
`default_nettype none

module l1_dcache
    import cache_pkg::*;
(
    input  wire               clk,
    input  wire               rst_n,

    // Processor port
    input  wire               i_read,
    input  wire               i_write,
    input  wire word_addr_t   i_addr,
    input  wire word_t        i_wdata,
    output word_t             o_rdata,
    output logic              o_stall,

    // Block memory port
    input  wire block_t       i_mem_rdata,
    input  wire               i_mem_ready,
    output logic              o_mem_read,
    output logic              o_mem_write,
    output block_addr_t       o_mem_addr,
    output block_t            o_mem_wdata
);

    way_access_if ways_if ();

    // Hit path and storage
    cache_ways u_ways (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_read      (i_read),
        .i_write     (i_write),
        .i_addr      (i_addr),
        .i_wdata     (i_wdata),
        .o_rdata     (o_rdata),
        .o_stall     (o_stall),
        .ways        (ways_if.storage)
    );

    // Miss path toward memory
    miss_controller u_miss (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_read      (i_read),
        .i_write     (i_write),
        .i_addr      (i_addr),
        .i_mem_rdata (i_mem_rdata),
        .i_mem_ready (i_mem_ready),
        .o_mem_read  (o_mem_read),
        .o_mem_write (o_mem_write),
        .o_mem_addr  (o_mem_addr),
        .o_mem_wdata (o_mem_wdata),
        .ctrl        (ways_if.controller)
    );

endmodule

`default_nettype wire

/* sim/block_mem_model.sv */
// Block memory model with fixed latency, one-cycle ready pulse and a write-back log
`default_nettype none

module block_mem_model
    import cache_pkg::*;
#(
    parameter int    LATENCY     = 6,
    parameter word_t PATTERN_XOR = 32'h0
) (
    input  wire              clk,
    input  wire              rst_n,
    input  wire              i_mem_read,
    input  wire              i_mem_write,
    input  wire block_addr_t i_mem_addr,
    input  wire block_t      i_mem_wdata,
    output block_t           o_mem_rdata,
    output logic             o_mem_ready,
    output int               o_wb_count,   // Write-backs seen so far
    output block_addr_t      o_wb_addr,    // Last write-back
    output block_t           o_wb_data
);

    block_t mem_blocks [block_addr_t];     // Blocks written back so far
    int     wait_cnt;

    function automatic block_t stored_block(input block_addr_t baddr);
        block_t blk;
        if (mem_blocks.exists(baddr)) begin
            return mem_blocks[baddr];
        end
        for (int o = 0; o < (1 << OFFSET_W); o++) begin
            blk[o*WORD_W +: WORD_W] = {2'b00, baddr, 2'(o)} ^ PATTERN_XOR;
        end
        return blk;
    endfunction

    always @(posedge clk) begin
        if (!rst_n) begin
            o_mem_ready <= 1'b0;
            o_mem_rdata <= '0;
            wait_cnt    <= 0;
            o_wb_count  <= 0;
            o_wb_addr   <= '0;
            o_wb_data   <= '0;
        end else if (o_mem_ready) begin
            o_mem_ready <= 1'b0;                   // Pulse lasts one cycle
        end else if (i_mem_read || i_mem_write) begin
            if (wait_cnt == LATENCY - 1) begin
                wait_cnt    <= 0;
                o_mem_ready <= 1'b1;
                if (i_mem_write) begin
                    mem_blocks[i_mem_addr] = i_mem_wdata;
                    o_wb_count <= o_wb_count + 1;
                    o_wb_addr  <= i_mem_addr;
                    o_wb_data  <= i_mem_wdata;
                end else begin
                    o_mem_rdata <= stored_block(i_mem_addr);
                end
            end else begin
                wait_cnt <= wait_cnt + 1;
            end
        end
    end

endmodule

`default_nettype wire

/* sim/tb_l1_dcache.sv */
// Testbench for the L1 data cache with directed tests checked against a reference model
`default_nettype none

module tb_l1_dcache
    import cache_pkg::*;
();

    localparam int    CLK_PERIOD   = 4;
    localparam int    RESET_CYCLES = 8;
    localparam int    MEM_LATENCY  = 6;
    localparam int    RAND_OPS     = 40;
    localparam int    NUM_OPS      = 20 + RAND_OPS;
    localparam int    WATCHDOG_CYC = RESET_CYCLES + NUM_OPS * (2 * MEM_LATENCY + 6);
    localparam word_t PATTERN_XOR  = 32'h5a5a_0f0f;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        i_read;
    logic        i_write;
    word_addr_t  i_addr;
    word_t       i_wdata;
    word_t       o_rdata;
    logic        o_stall;
    logic        o_mem_read;
    logic        o_mem_write;
    block_addr_t o_mem_addr;
    block_t      o_mem_wdata;
    block_t      mem_rdata;
    logic        mem_ready;
    int          wb_count;
    block_addr_t wb_addr;
    block_t      wb_data;

    int          seed = 32'h03b5_22ba;
    int          errors = 0;
    int          checks = 0;

    // Reference model of word values and per-set way state
    word_t       ref_words [word_addr_t];
    logic        ref_valid [2][NUM_SETS];
    logic        ref_dirty [2][NUM_SETS];
    tag_t        ref_tag   [2][NUM_SETS];
    logic        ref_lru   [NUM_SETS];

    always #(CLK_PERIOD / 2) clk = ~clk;

    l1_dcache dut0 (
        .clk(clk), .rst_n(rst_n),
        .i_read(i_read), .i_write(i_write), .i_addr(i_addr), .i_wdata(i_wdata),
        .o_rdata(o_rdata), .o_stall(o_stall),
        .i_mem_rdata(mem_rdata), .i_mem_ready(mem_ready),
        .o_mem_read(o_mem_read), .o_mem_write(o_mem_write),
        .o_mem_addr(o_mem_addr), .o_mem_wdata(o_mem_wdata)
    );

    block_mem_model #(.LATENCY(MEM_LATENCY), .PATTERN_XOR(PATTERN_XOR)) mem0 (
        .clk(clk), .rst_n(rst_n),
        .i_mem_read(o_mem_read), .i_mem_write(o_mem_write),
        .i_mem_addr(o_mem_addr), .i_mem_wdata(o_mem_wdata),
        .o_mem_rdata(mem_rdata), .o_mem_ready(mem_ready),
        .o_wb_count(wb_count), .o_wb_addr(wb_addr), .o_wb_data(wb_data)
    );

    // ------------------------------------------------------------
    // Compare tasks
    // ------------------------------------------------------------
    task automatic check_word(input string name, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_block(input string name, input block_t got, input block_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_addr(input string name, input block_addr_t got, input block_addr_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch %s: got %h, expected %h", name, got, exp);
        end
    endtask

    // ------------------------------------------------------------
    // Reference helpers
    // ------------------------------------------------------------
    function automatic word_addr_t make_addr(input int tag, input int set, input int off);
        return {tag_t'(tag), set_idx_t'(set), 2'(off)};
    endfunction

    function automatic word_t ref_word(input word_addr_t addr);
        if (ref_words.exists(addr)) begin
            return ref_words[addr];
        end
        return {2'b00, addr} ^ PATTERN_XOR;   // Untouched memory pattern
    endfunction

    function automatic block_t ref_block(input block_addr_t baddr);
        block_t blk;
        for (int o = 0; o < (1 << OFFSET_W); o++) begin
            blk[o*WORD_W +: WORD_W] = ref_word({baddr, 2'(o)});
        end
        return blk;
    endfunction

    // One processor access held until o_stall drops and then checked
    task automatic cache_access(input logic is_write, input word_addr_t addr, input word_t wdata);
        tag_t        tag;
        set_idx_t    set;
        logic        way;
        logic        exp_miss;
        logic        exp_wb;
        block_addr_t exp_wb_addr;
        block_t      exp_wb_data;
        int          wb_before;
        tag         = addr[ADDR_W-1 -: TAG_W];
        set         = addr[OFFSET_W +: SET_W];
        exp_miss    = 1'b1;
        exp_wb      = 1'b0;
        exp_wb_addr = '0;
        exp_wb_data = '0;
        way         = ref_lru[set];             // Victim unless a way hits
        for (int w = 0; w < 2; w++) begin
            if (ref_valid[w][set] && ref_tag[w][set] == tag) begin
                exp_miss = 1'b0;
                way      = 1'(w);
            end
        end
        if (exp_miss && ref_valid[way][set] && ref_dirty[way][set]) begin
            exp_wb      = 1'b1;
            exp_wb_addr = {ref_tag[way][set], set};
            exp_wb_data = ref_block(exp_wb_addr);
        end
        wb_before = wb_count;

        @(posedge clk);
        i_read  <= ~is_write;
        i_write <= is_write;
        i_addr  <= addr;
        i_wdata <= wdata;
        @(negedge clk);
        check_bit("o_stall", o_stall, exp_miss);
        while (o_stall) begin
            @(negedge clk);
        end
        check_bit("o_mem_read", o_mem_read, 1'b0);
        check_bit("o_mem_write", o_mem_write, 1'b0);
        if (!is_write) begin
            check_word("o_rdata", o_rdata, ref_word(addr));
        end
        @(posedge clk);                         // Write hit and LRU commit on this edge
        i_read  <= 1'b0;
        i_write <= 1'b0;

        if (exp_miss) begin
            ref_valid[way][set] = 1'b1;
            ref_dirty[way][set] = 1'b0;
            ref_tag[way][set]   = tag;
        end
        if (is_write) begin
            ref_words[addr]     = wdata;
            ref_dirty[way][set] = 1'b1;
        end
        ref_lru[set] = ~way;

        if (wb_count - wb_before != int'(exp_wb)) begin
            errors++;
            $display("error: access to %h caused %0d write-backs, expected %0d",
                     addr, wb_count - wb_before, int'(exp_wb));
        end else if (exp_wb) begin
            check_addr("o_mem_addr", wb_addr, exp_wb_addr);
            check_block("o_mem_wdata", wb_data, exp_wb_data);
        end
    endtask

    // ------------------------------------------------------------
    // Directed tests
    // ------------------------------------------------------------
    task automatic test_reset();
        @(negedge clk);
        check_bit("o_stall", o_stall, 1'b0);
        check_bit("o_mem_read", o_mem_read, 1'b0);
        check_bit("o_mem_write", o_mem_write, 1'b0);
    endtask

    task automatic test_read_miss();
        cache_access(1'b0, make_addr(5, 1, 2), '0);
        cache_access(1'b0, make_addr(5, 1, 0), '0);   // Same block hits
    endtask

    task automatic test_write_hit();
        cache_access(1'b1, make_addr(5, 1, 3), 32'h1234_abcd);
        cache_access(1'b0, make_addr(5, 1, 3), '0);
    endtask

    task automatic test_write_miss();
        cache_access(1'b1, make_addr(6, 2, 1), 32'hcafe_f00d);
        for (int o = 0; o < 4; o++) begin
            cache_access(1'b0, make_addr(6, 2, o), '0);
        end
    endtask

    task automatic test_dirty_eviction();
        int wb_start;
        cache_access(1'b1, make_addr(1, 3, 2), 32'hdead_beef);  // Dirty block in way 0
        cache_access(1'b0, make_addr(2, 3, 0), '0);             // Way 1 makes way 0 the victim
        wb_start = wb_count;
        cache_access(1'b0, make_addr(3, 3, 1), '0);
        if (wb_count - wb_start != 1) begin
            errors++;
            $display("error: dirty eviction gave %0d write-backs instead of one",
                     wb_count - wb_start);
        end
        cache_access(1'b0, make_addr(1, 3, 2), '0);             // Refetched from memory
    endtask

    task automatic test_random_mix();
        logic [31:0] r;
        word_t       wdata;
        for (int n = 0; n < RAND_OPS; n++) begin
            r     = $random(seed);
            wdata = $random(seed);
            cache_access(r[5], make_addr(8 + int'(r[1:0]), int'(r[2]), int'(r[4:3])), wdata);
        end
        // Two fresh tags per set push every dirty way out to memory
        for (int s = 0; s < 2; s++) begin
            cache_access(1'b0, make_addr(20, s, 0), '0);
            cache_access(1'b0, make_addr(21, s, 0), '0);
        end
    endtask

    // ------------------------------------------------------------
    // Main sequence and watchdog
    // ------------------------------------------------------------
    initial begin
        rst_n   <= 1'b0;
        i_read  <= 1'b0;
        i_write <= 1'b0;
        i_addr  <= '0;
        i_wdata <= '0;
        for (int s = 0; s < NUM_SETS; s++) begin
            ref_lru[s] = 1'b0;
            for (int w = 0; w < 2; w++) begin
                ref_valid[w][s] = 1'b0;
                ref_dirty[w][s] = 1'b0;
                ref_tag[w][s]   = '0;
            end
        end
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;

        test_reset();
        test_read_miss();
        test_write_hit();
        test_write_miss();
        test_dirty_eviction();
        test_random_mix();

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYC * CLK_PERIOD);
        $display("error: watchdog expired, the cache did not finish its requests");
        $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
logic/cache_pkg.sv
logic/way_access_if.sv
logic/cache_ways.sv
logic/miss_controller.sv
logic/l1_dcache.sv
sim/block_mem_model.sv
sim/tb_l1_dcache.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the L1 data cache testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -f "$LOG"

verilator --binary --timing --assert -j 0 \
    --top-module tb_l1_dcache \
    -Mdir obj_dir \
    -f filelist.f > "$LOG" 2>&1 \
    && ./obj_dir/Vtb_l1_dcache >> "$LOG" 2>&1 \
    || echo "build or simulation ended with an error" >> "$LOG"

if grep -qx "test passed" "$LOG"; then
    echo "PASS (see $LOG)"
    exit 0
else
    echo "FAIL (see $LOG)"
    exit 1
fi
